// ==== Makefile ====
# Verilator build and run of the eforth testbench
LOG := sim.log

sim:
	verilator --binary --timing --assert -f files.f --top-module eforth_tb -o eforth_sim
	./obj_dir/eforth_sim | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

// ==== bench/eforth_tests.svh ====
////////////////////
// directed tests, one task each
////////////////////
`ifndef EFORTH_TESTS_SVH
`define EFORTH_TESTS_SVH

// countdown from n, leaves 0 on top
task automatic build_countdown(input cell_t n);
    addr_t loop_at;
    addr_t exit_at;
    emit_lit(n);
    loop_at = org + addr_t'(prog.size());
    exit_at = loop_at + addr_t'(LIT_BYTES + 3 + 2 * (BRANCH_BYTES + 1));   // the bye
    emit_lit(32'd1);
    emit_op(OP_SUB);
    emit_op(OP_DUP);
    emit_branch(OP_ZBRAN, exit_at);   // pops the dup copy
    emit_branch(OP_BRAN, loop_at);
    emit_op(OP_BYE);
endtask

task automatic test_stack_ops();
    new_program(16'h0000);
    emit_lit($random(seed));
    emit_lit($random(seed));
    emit_modeled(OP_OVER);
    emit_modeled(OP_SWAP);
    emit_modeled(OP_DROP);
    emit_modeled(OP_DUP);
    emit_op(OP_BYE);
    load_program();
    run_program(org, 0);
    check_result(model_q[$], depth_t'(model_q.size()), 1'b0);
endtask

task automatic test_alu();
    opcode_e alu_ops[8] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_LT, OP_NEG, OP_ZEQ};
    cell_t   a;
    cell_t   b;
    for (int r = 0; r < 3; r++) begin
        a = $random(seed);
        b = $random(seed);
        if (r == 1) b = '0;   // zeq true
        if (r == 2) b = a;    // lt on equal operands
        foreach (alu_ops[k]) begin
            new_program(16'h0100);
            if (alu_ops[k] != OP_NEG && alu_ops[k] != OP_ZEQ)
                emit_lit(a);
            emit_lit(b);
            emit_modeled(alu_ops[k]);
            emit_op(OP_BYE);
            load_program();
            run_program(org, 0);
            check_result(model_q[$], 8'd1, 1'b0);
        end
    end
endtask

task automatic test_branches();
    cell_t mark;
    mark = $random(seed);
    new_program(16'h0200);
    emit_lit(mark);   // stays under the loop
    build_countdown(cell_t'(3 + ($unsigned($random(seed)) % 6)));
    load_program();
    run_program(org, 0);
    check_result(32'd0, 8'd2, 1'b0);
    // bran jumps over a bad byte
    new_program(16'h0300);
    emit_lit(mark);
    emit_branch(OP_BRAN, org + addr_t'(prog.size() + BRANCH_BYTES + 2));
    prog.push_back(8'hff);
    emit_op(OP_BYE);
    load_program();
    run_program(org, 0);
    check_result(mark, 8'd1, 1'b0);
endtask

task automatic test_faults();
    new_program(16'h0400);
    emit_op(OP_DROP);   // nothing to drop
    emit_op(OP_BYE);
    load_program();
    run_program(org, 0);
    check_result(32'd0, 8'd0, 1'b1);
    // SS_DEPTH cells plus tos fit, the next literal overflows
    new_program(16'h0500);
    for (int i = 0; i < SS_DEPTH + 2; i++)
        emit_lit(cell_t'(32'h1000 + i));
    emit_op(OP_BYE);
    load_program();
    run_program(org, 0);
    check_result(cell_t'(32'h1000 + SS_DEPTH), depth_t'(SS_DEPTH + 1), 1'b1);
    new_program(16'h0600);
    emit_lit(32'h0bad_c0de);
    prog.push_back(8'h05);   // unused code
    emit_op(OP_BYE);
    load_program();
    run_program(org, 0);
    check_result(32'h0bad_c0de, 8'd1, 1'b1);
endtask

task automatic test_handshakes();
    cell_t a;
    cell_t b;
    int    stall;
    a = $random(seed);
    b = $random(seed);
    stall = 2 + int'($unsigned($random(seed)) % 12);
    new_program(16'h0700);
    emit_lit(a);
    emit_lit(b);
    emit_op(OP_ADD);
    emit_op(OP_BYE);
    load_program();
    run_program(org, stall);   // result must hold while done_ready is low
    check_result(a + b, 8'd1, 1'b0);
    // host write attempt on the first opcode while the loop runs
    new_program(16'h0800);
    build_countdown(32'd8);
    load_program();
    start_run(org);
    @(posedge clk);
    load_valid <= 1'b1;
    load_addr  <= org;
    load_data  <= 8'hff;
    repeat (8) begin
        @(negedge clk);
        check_flag("load_ready", load_ready, 1'b0);
    end
    @(posedge clk);
    load_valid <= 1'b0;
    finish_run(0);
    check_result(32'd0, 8'd1, 1'b0);
    run_program(org, 0);   // image unchanged
    check_result(32'd0, 8'd1, 1'b0);
    // second run right after a run that left three items
    new_program(16'h0900);
    emit_lit(a);
    emit_lit(b);
    emit_lit(a ^ b);
    emit_op(OP_BYE);
    load_program();
    new_program(16'h0a00);
    emit_lit(b);
    emit_op(OP_BYE);
    load_program();
    run_program(16'h0900, 0);
    check_result(a ^ b, 8'd3, 1'b0);
    run_program(16'h0a00, 0);
    check_result(b, 8'd1, 1'b0);
endtask

`endif

// ==== bench/eforth_tb.sv ====
////////////////////
// eforth subsystem testbench
// clock, reset, dut, load/run helpers, compare tasks, stack model
////////////////////
`timescale 1ns/100ps
`default_nettype none

module eforth_tb;
    import eforth_mem_pkg::*;
    import eforth_isa_pkg::*;

    localparam int SS_DEPTH   = 16;
    localparam int WAIT_LIMIT = 4000;   // cycles per wait loop

    logic   clk = 1'b0;
    logic   rst;
    logic   load_valid;
    logic   load_ready;
    addr_t  load_addr;
    byte_t  load_data;
    logic   run_valid;
    logic   run_ready;
    addr_t  run_ip;
    logic   done_valid;
    logic   done_ready;
    cell_t  done_tos;
    depth_t done_depth;
    logic   done_fault;

    integer seed;
    byte_t  prog[$];      // program image under construction
    addr_t  org;          // load address of prog[0]
    cell_t  model_q[$];   // reference stack, back is tos
    cell_t  res_tos;      // last captured result
    depth_t res_depth;
    bit     res_fault;

    always #20 clk = ~clk;   // 40 ns period

    eforth_top #(.SS_DEPTH(SS_DEPTH)) dut0 (
        .clk        (clk),
        .rst        (rst),
        .load_valid (load_valid),
        .load_ready (load_ready),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .run_valid  (run_valid),
        .run_ready  (run_ready),
        .run_ip     (run_ip),
        .done_valid (done_valid),
        .done_ready (done_ready),
        .done_tos   (done_tos),
        .done_depth (done_depth),
        .done_fault (done_fault)
    );

    task automatic fail_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic timed_out(input string what);
        $display("timed out after %0d cycles waiting for %s", WAIT_LIMIT, what);
        fail_run();
    endtask

    task automatic check_cell(input string name, input cell_t got, input cell_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_depth(input string name, input depth_t got, input depth_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_flag(input string name, input bit got, input bit exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s = %b, expected %b", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_result(input cell_t exp_tos, input depth_t exp_depth, input bit exp_fault);
        check_cell("done_tos", res_tos, exp_tos);
        check_depth("done_depth", res_depth, exp_depth);
        check_flag("done_fault", res_fault, exp_fault);
    endtask

    // program image building
    function automatic void new_program(input addr_t base);
        prog.delete();
        model_q.delete();
        org = base;
    endfunction

    function automatic void emit_op(input opcode_e op);
        prog.push_back(byte_t'(op));
    endfunction

    function automatic void emit_lit(input cell_t v);
        emit_op(OP_DOLIT);
        for (int i = 0; i < LIT_BYTES; i++)
            prog.push_back(v[8*i +: 8]);   // lsb first
        model_q.push_back(v);
    endfunction

    function automatic void emit_branch(input opcode_e op, input addr_t target);
        emit_op(op);
        for (int i = 0; i < BRANCH_BYTES; i++)
            prog.push_back(target[8*i +: 8]);
    endfunction

    // replace s0 and tos by one result
    function automatic void fold(input cell_t r);
        void'(model_q.pop_back());
        model_q[model_q.size() - 1] = r;
    endfunction

    // forth semantics on the queue, s0 is the item under tos
    function automatic void model_op(input opcode_e op);
        int    n;
        cell_t t;
        cell_t s;
        n = model_q.size();
        t = model_q[n - 1];
        s = (n > 1) ? model_q[n - 2] : '0;
        case (op)
            OP_DUP:  model_q.push_back(t);
            OP_DROP: void'(model_q.pop_back());
            OP_OVER: model_q.push_back(s);
            OP_SWAP: begin
                model_q[n - 1] = s;
                model_q[n - 2] = t;
            end
            OP_ADD:  fold(s + t);
            OP_SUB:  fold(s - t);
            OP_AND:  fold(s & t);
            OP_OR:   fold(s | t);
            OP_XOR:  fold(s ^ t);
            OP_LT:   fold({$bits(cell_t){$signed(s) < $signed(t)}});   // true is all ones
            OP_NEG:  model_q[n - 1] = -t;
            OP_ZEQ:  model_q[n - 1] = {$bits(cell_t){t == '0}};
            default: model_q[n - 1] = t;
        endcase
    endfunction

    function automatic void emit_modeled(input opcode_e op);
        emit_op(op);
        model_op(op);
    endfunction

    // host writes prog at org, one byte per handshake
    task automatic load_program();
        int waited;
        @(posedge clk);
        foreach (prog[i]) begin
            load_valid <= 1'b1;
            load_addr  <= org + addr_t'(i);
            load_data  <= prog[i];
            waited = 0;
            @(negedge clk);
            while (!load_ready) begin
                waited++;
                if (waited > WAIT_LIMIT) timed_out("load_ready");
                @(negedge clk);
            end
            @(posedge clk);   // byte taken here
        end
        load_valid <= 1'b0;
    endtask

    task automatic start_run(input addr_t ip);
        int waited;
        waited = 0;
        @(posedge clk);
        run_valid <= 1'b1;
        run_ip    <= ip;
        @(negedge clk);
        while (!run_ready) begin
            waited++;
            if (waited > WAIT_LIMIT) timed_out("run_ready");
            @(negedge clk);
        end
        @(posedge clk);
        run_valid <= 1'b0;
    endtask

    // wait for the result, hold it for stall cycles, then take it
    task automatic finish_run(input int stall);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!done_valid) begin
            waited++;
            if (waited > WAIT_LIMIT) timed_out("done_valid");
            @(negedge clk);
        end
        res_tos   = done_tos;
        res_depth = done_depth;
        res_fault = done_fault;
        repeat (stall) begin
            @(negedge clk);
            check_flag("run_ready", run_ready, 1'b0);     // result still pending
            check_flag("load_ready", load_ready, 1'b0);   // bus claimed until taken
            check_flag("done_valid", done_valid, 1'b1);
            check_cell("done_tos", done_tos, res_tos);
            check_depth("done_depth", done_depth, res_depth);
            check_flag("done_fault", done_fault, res_fault);
        end
        @(posedge clk);
        done_ready <= 1'b1;
        @(posedge clk);   // handshake edge
        done_ready <= 1'b0;
    endtask

    task automatic run_program(input addr_t ip, input int stall);
        start_run(ip);
        finish_run(stall);
    endtask

    `include "eforth_tests.svh"

    initial begin
        seed = 81460;
        rst        <= 1'b1;
        load_valid <= 1'b0;
        load_addr  <= '0;
        load_data  <= '0;
        run_valid  <= 1'b0;
        run_ip     <= '0;
        done_ready <= 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_flag("run_ready", run_ready, 1'b1);    // idle after reset
        check_flag("load_ready", load_ready, 1'b1);
        check_flag("done_valid", done_valid, 1'b0);
        test_stack_ops();
        test_alu();
        test_branches();
        test_faults();
        test_handshakes();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+bench
rtl/eforth_mem_pkg.sv
rtl/eforth_isa_pkg.sv
rtl/eforth_if.sv
rtl/byte_ram.sv
rtl/data_stack.sv
rtl/eforth_core.sv
rtl/eforth_top.sv
bench/eforth_tb.sv

// ==== rtl/byte_ram.sv ====
////////////////////
// byte program memory
// host load port, core read port
////////////////////
`timescale 1ns/100ps
`default_nettype none

module byte_ram (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  load_valid,
    output logic                  load_ready,
    input  eforth_mem_pkg::addr_t load_addr,
    input  eforth_mem_pkg::byte_t load_data,
    mem_bus_if.ram                bus
);
    import eforth_mem_pkg::*;

    localparam int AW = $clog2(RAM_BYTES);   // decoded address bits

    byte_t mem [RAM_BYTES];

    // host may write only while no run owns the bus
    assign load_ready = !bus.claim;

    // host write, visible to reads on the next cycle
    always_ff @(posedge clk) begin
        if (load_valid && load_ready) begin
            mem[load_addr[AW-1:0]] <= load_data;
        end
    end

    // registered read, one cycle latency
    always_ff @(posedge clk) begin
        if (bus.rd_en) begin
            bus.rdata <= mem[bus.addr[AW-1:0]];   // upper address bits ignored
        end
    end

    // core reads only inside a claimed run
    a_rd_claimed: assert property (
        @(posedge clk) disable iff (rst)
        bus.rd_en |-> bus.claim
    );

endmodule

`default_nettype wire

// ==== rtl/data_stack.sv ====
////////////////////
// data stack under the cached tos
////////////////////
`timescale 1ns/100ps
`default_nettype none

module data_stack #(
    parameter int SS_DEPTH = 16
) (
    input  logic  clk,
    input  logic  rst,
    stack_if.stack stk
);
    import eforth_mem_pkg::*;

    // pointer width, at least one bit
    localparam int PW = (SS_DEPTH > 1) ? $clog2(SS_DEPTH) : 1;

    cell_t         mem [SS_DEPTH];
    depth_t        count;       // cells held
    logic [PW-1:0] wr_ptr;      // next free slot
    logic [PW-1:0] rd_ptr;      // slot of s0

    assign wr_ptr = PW'(count);
    assign rd_ptr = PW'(count - depth_t'(1));

    // fill level
    always_ff @(posedge clk) begin
        if (rst || stk.clear) begin
            count <= '0;
        end else if (stk.push) begin
            count <= count + depth_t'(1);
        end else if (stk.pop) begin
            count <= count - depth_t'(1);
        end
    end

    // cell store
    always_ff @(posedge clk) begin
        if (stk.push) begin
            mem[wr_ptr] <= stk.din;
        end
    end

    // s0 read straight from the array
    // after a pop the next cell shows up one cycle later
    assign stk.s0    = mem[rd_ptr];
    assign stk.count = count;
    assign stk.full  = (count == depth_t'(SS_DEPTH));
    assign stk.empty = (count == '0);

    // core must check depth before it moves cells
    a_no_push_full: assert property (
        @(posedge clk) disable iff (rst)
        stk.push |-> !stk.full
    );

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (rst)
        stk.pop |-> !stk.empty
    );

endmodule

`default_nettype wire

// ==== rtl/eforth_core.sv ====
////////////////////
// eforth inner interpreter
// fetch, decode/execute, inline operand assembly
////////////////////
`timescale 1ns/100ps
`default_nettype none

module eforth_core #(
    parameter int SS_DEPTH = 16
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   run_valid,
    input  eforth_mem_pkg::addr_t  run_ip,
    output logic                   run_ready,
    output logic                   done_valid,
    output eforth_mem_pkg::cell_t  done_tos,
    output eforth_mem_pkg::depth_t done_depth,
    output logic                   done_fault,
    input  logic                   done_ready,
    mem_bus_if.core                bus,
    stack_if.core                  stk
);
    import eforth_mem_pkg::*;
    import eforth_isa_pkg::*;

    typedef enum logic [2:0] {IDLE, FETCH, EXEC, INLINE, DONE} state_e;

    state_e     state;
    addr_t      ip;
    cell_t      tos;
    logic       tos_valid;   // tos holds an item
    logic       fault;
    logic       swap_pend;   // old tos still owed to the stack
    logic [2:0] inl_cnt;     // inline bytes left
    cell_t      asm_sr;      // operand assembly, lsb byte first
    opcode_e    op_q;        // opcode owning the inline bytes

    opcode_e    op;
    cell_t      asm_next;
    addr_t      target;
    depth_t     depth;
    logic [1:0] need;        // items the opcode consumes
    logic       grows;       // opcode adds an item
    logic       known;
    logic       bad;
    logic       last_byte;
    logic       run_fire;
    logic       done_fire;

    assign op        = opcode_e'(bus.rdata);   // only meaningful in EXEC
    assign asm_next  = {bus.rdata, asm_sr[$bits(cell_t)-1:8]};
    assign target    = asm_next[$bits(cell_t)-1 -: $bits(addr_t)];
    assign depth     = stk.count + depth_t'(tos_valid);
    assign last_byte = (inl_cnt == 3'd1);
    assign run_fire  = (state == IDLE) && run_valid;
    assign done_fire = (state == DONE) && done_ready;

    // stack requirements per opcode
    always_comb begin
        need  = 2'd0;
        grows = 1'b0;
        known = 1'b1;
        case (op)
            OP_NOP, OP_BRAN, OP_BYE: need = 2'd0;
            OP_DOLIT: grows = 1'b1;
            OP_ZBRAN, OP_DROP, OP_NEG, OP_ZEQ: need = 2'd1;
            OP_DUP: begin
                need  = 2'd1;
                grows = 1'b1;
            end
            OP_OVER: begin
                need  = 2'd2;
                grows = 1'b1;
            end
            OP_SWAP, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_LT: need = 2'd2;
            default: known = 1'b0;
        endcase
    end

    // underflow, overflow past SS_DEPTH+1 items, or unknown byte
    assign bad = !known || (depth < depth_t'(need))
               || (grows && depth == depth_t'(SS_DEPTH + 1));

    assign bus.claim = (state != IDLE);     // drops with the done handshake
    assign bus.addr  = ip;
    assign stk.clear = run_fire || done_fire;
    assign run_ready = (state == IDLE);
    assign done_valid = (state == DONE);
    assign done_tos   = tos;
    assign done_depth = depth;
    assign done_fault = fault;

    // memory reads and stack strobes
    always_comb begin
        bus.rd_en = 1'b0;
        stk.push  = 1'b0;
        stk.pop   = 1'b0;
        stk.din   = swap_pend ? asm_sr : tos;
        case (state)
            FETCH: begin
                bus.rd_en = 1'b1;
                stk.push  = swap_pend;   // finish a swap
            end
            EXEC: if (!bad) begin
                case (op)
                    OP_DOLIT, OP_BRAN, OP_ZBRAN: bus.rd_en = 1'b1;  // first inline byte
                    OP_DUP, OP_OVER: stk.push = 1'b1;
                    OP_DROP: stk.pop = !stk.empty;
                    OP_SWAP, OP_ADD, OP_SUB, OP_AND,
                    OP_OR, OP_XOR, OP_LT: stk.pop = 1'b1;
                    default: stk.pop = 1'b0;
                endcase
            end
            INLINE: begin
                bus.rd_en = !last_byte;
                if (last_byte && op_q == OP_DOLIT) stk.push = tos_valid;
                if (last_byte && op_q == OP_ZBRAN) stk.pop = !stk.empty;
            end
            default: bus.rd_en = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            ip        <= '0;
            tos       <= '0;
            tos_valid <= 1'b0;
            fault     <= 1'b0;
            swap_pend <= 1'b0;
            inl_cnt   <= '0;
        end else begin
            case (state)
                IDLE: if (run_valid) begin
                    state     <= FETCH;
                    ip        <= run_ip;
                    tos       <= '0;
                    tos_valid <= 1'b0;
                    fault     <= 1'b0;
                    swap_pend <= 1'b0;
                end
                FETCH: begin
                    ip        <= ip + addr_t'(1);
                    swap_pend <= 1'b0;
                    state     <= EXEC;
                end
                EXEC: if (bad) begin
                    fault <= 1'b1;    // tos left as it was
                    state <= DONE;
                end else begin
                    state <= FETCH;
                    case (op)
                        OP_DOLIT: begin
                            inl_cnt <= 3'(LIT_BYTES);
                            ip      <= ip + addr_t'(1);
                            state   <= INLINE;
                        end
                        OP_BRAN, OP_ZBRAN: begin
                            inl_cnt <= 3'(BRANCH_BYTES);
                            ip      <= ip + addr_t'(1);
                            state   <= INLINE;
                        end
                        OP_BYE: state <= DONE;
                        OP_DROP: begin
                            if (stk.empty) tos_valid <= 1'b0;
                            else tos <= stk.s0;
                        end
                        OP_OVER: tos <= stk.s0;
                        OP_SWAP: begin
                            tos       <= stk.s0;
                            swap_pend <= 1'b1;   // old tos parked in asm_sr
                        end
                        OP_ADD: tos <= stk.s0 + tos;
                        OP_SUB: tos <= stk.s0 - tos;
                        OP_AND: tos <= stk.s0 & tos;
                        OP_OR:  tos <= stk.s0 | tos;
                        OP_XOR: tos <= stk.s0 ^ tos;
                        OP_NEG: tos <= -tos;
                        OP_ZEQ: tos <= (tos == '0) ? '1 : '0;
                        OP_LT:  tos <= ($signed(stk.s0) < $signed(tos)) ? '1 : '0;
                        default: tos <= tos;    // nop, dup
                    endcase
                end
                INLINE: begin
                    inl_cnt <= inl_cnt - 3'd1;
                    if (!last_byte) begin
                        ip <= ip + addr_t'(1);
                    end else begin
                        state <= FETCH;
                        case (op_q)
                            OP_DOLIT: begin
                                tos       <= asm_next;
                                tos_valid <= 1'b1;
                            end
                            OP_BRAN: ip <= target;
                            default: begin      // 0bran, test then pop
                                if (tos == '0) ip <= target;
                                if (stk.empty) tos_valid <= 1'b0;
                                else tos <= stk.s0;
                            end
                        endcase
                    end
                end
                DONE: if (done_ready) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // operand shift and opcode latch
    always_ff @(posedge clk) begin
        if (state == EXEC) begin
            op_q   <= op;
            asm_sr <= tos;         // swap keeps old tos here, inline shifts it out
        end else if (state == INLINE) begin
            asm_sr <= asm_next;
        end
    end

    // result held steady under back-pressure
    a_done_hold: assert property (
        @(posedge clk) disable iff (rst)
        done_valid && !done_ready |=> done_valid && $stable(done_tos)
            && $stable(done_depth) && $stable(done_fault)
    );

endmodule

`default_nettype wire

// ==== rtl/eforth_if.sv ====
////////////////////
// program memory bus and data stack port
////////////////////
`timescale 1ns/100ps
`default_nettype none

// core read port into program memory
interface mem_bus_if;
    import eforth_mem_pkg::*;

    logic  claim;   // high for the whole run, blocks host loads
    logic  rd_en;
    addr_t addr;
    byte_t rdata;   // valid one cycle after rd_en

    modport core (
        output claim,
        output rd_en,
        output addr,
        input  rdata
    );

    modport ram (
        input  claim,
        input  rd_en,
        input  addr,
        output rdata
    );
endinterface

// cells below the cached tos
interface stack_if;
    import eforth_mem_pkg::*;

    logic   push;   // never together with pop
    logic   pop;
    logic   clear;  // empty the stack at run start and end
    cell_t  din;
    cell_t  s0;     // cell just under tos
    depth_t count;
    logic   full;
    logic   empty;

    modport core (
        output push, pop, clear, din,
        input  s0, count, full, empty
    );

    modport stack (
        input  push, pop, clear, din,
        output s0, count, full, empty
    );
endinterface

`default_nettype wire

// ==== rtl/eforth_isa_pkg.sv ====
////////////////////
// opcode encoding and inline byte formats
////////////////////
`default_nettype none

package eforth_isa_pkg;

    // byte opcodes, one per fetch
    typedef enum logic [7:0] {
        // flow
        OP_NOP   = 8'd0,
        OP_DOLIT = 8'd1,   // followed by LIT_BYTES literal bytes
        OP_BRAN  = 8'd2,   // followed by BRANCH_BYTES target bytes
        OP_ZBRAN = 8'd3,   // branch taken when popped tos is zero
        OP_BYE   = 8'd4,
        // stack
        OP_DUP   = 8'd16,
        OP_DROP  = 8'd17,
        OP_OVER  = 8'd18,
        OP_SWAP  = 8'd19,
        // alu
        OP_ADD   = 8'd32,
        OP_SUB   = 8'd33,  // s0 - tos
        OP_AND   = 8'd34,
        OP_OR    = 8'd35,
        OP_XOR   = 8'd36,
        OP_NEG   = 8'd37,
        // logic, true is all ones
        OP_ZEQ   = 8'd48,
        OP_LT    = 8'd49   // signed s0 < tos
    } opcode_e;

    // inline operands, least significant byte first
    localparam int LIT_BYTES    = 4;
    localparam int BRANCH_BYTES = 2;

endpackage

`default_nettype wire

// ==== rtl/eforth_mem_pkg.sv ====
////////////////////
// data widths and memory size
////////////////////
`default_nettype none

package eforth_mem_pkg;

    typedef logic [7:0]  byte_t;   // program memory byte
    typedef logic [31:0] cell_t;   // stack cell
    typedef logic [15:0] addr_t;   // byte address, wraps mod RAM_BYTES
    typedef logic [7:0]  depth_t;  // item count incl tos

    // program memory size in bytes
    // only the low address bits are decoded
    localparam int RAM_BYTES = 4096;

endpackage

`default_nettype wire

// ==== rtl/eforth_top.sv ====
////////////////////
// interpreter subsystem top
////////////////////
`timescale 1ns/100ps
`default_nettype none

module eforth_top #(
    parameter int SS_DEPTH = 16    // cells below tos, at most 254
) (
    input  logic                   clk,
    input  logic                   rst,
    // host program load
    input  logic                   load_valid,
    output logic                   load_ready,
    input  eforth_mem_pkg::addr_t  load_addr,
    input  eforth_mem_pkg::byte_t  load_data,
    // run start
    input  logic                   run_valid,
    output logic                   run_ready,
    input  eforth_mem_pkg::addr_t  run_ip,
    // run result
    output logic                   done_valid,
    input  logic                   done_ready,
    output eforth_mem_pkg::cell_t  done_tos,
    output eforth_mem_pkg::depth_t done_depth,
    output logic                   done_fault
);

    mem_bus_if bus ();
    stack_if   stk ();

    byte_ram u_ram (
        .clk        (clk),
        .rst        (rst),
        .load_valid (load_valid),
        .load_ready (load_ready),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .bus        (bus.ram)
    );

    data_stack #(.SS_DEPTH(SS_DEPTH)) u_stack (
        .clk (clk),
        .rst (rst),
        .stk (stk.stack)
    );

    eforth_core #(.SS_DEPTH(SS_DEPTH)) u_core (
        .clk        (clk),
        .rst        (rst),
        .run_valid  (run_valid),
        .run_ip     (run_ip),
        .run_ready  (run_ready),
        .done_valid (done_valid),
        .done_tos   (done_tos),
        .done_depth (done_depth),
        .done_fault (done_fault),
        .done_ready (done_ready),
        .bus        (bus.core),
        .stk        (stk.core)
    );

endmodule

`default_nettype wire
